// File: run_sim.sh
#!/bin/sh
# Build the front end testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_n64_frontend -o sim_frontend
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_frontend)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^All tests passed$"; then
	exit 0
fi
exit 1

// File: src/aspect_ratio_select.sv
// Registers the HDMI aspect ratio from video standard, vertical crop and user override
`timescale 1ns/1ps
`default_nettype none

module aspect_ratio_select (
	input wire logic clk_1x,
	input wire logic RESET,
	input wire n64_frontend_pkg::video_cfg_t cfg,
	output n64_frontend_pkg::ar_coord_t ar_x,
	output n64_frontend_pkg::ar_coord_t ar_y
);
	import n64_frontend_pkg::*;

	ar_coord_t core_x;
	ar_coord_t core_y;
	ar_coord_t next_x;
	ar_coord_t next_y;

	// ============================================================
	// Core ratio table
	// ============================================================
	always_comb begin
		next_x = core_x;
		next_y = core_y;
		if (cfg.blanks_off || cfg.direct_fb) begin
			next_x = 13'd4;
			next_y = 13'd3;
		end else if (cfg.pal) begin
			case (cfg.crop)
				2'd0: begin
					next_x = 13'd512;
					next_y = 13'd387;
				end
				2'd1: begin
					next_x = 13'd1024;
					next_y = 13'd731;
				end
				2'd2: begin
					next_x = 13'd2048;
					next_y = 13'd1419;
				end
				// Crop 3 holds the last ratio
				default: ;
			endcase
		end else begin
			case (cfg.crop)
				2'd0: begin
					next_x = 13'd512;
					next_y = 13'd381;
				end
				2'd1: begin
					next_x = 13'd1280;
					next_y = 13'd889;
				end
				2'd2: begin
					next_x = 13'd2560;
					next_y = 13'd1714;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= 13'd4;
			core_y <= 13'd3;
			ar_x <= 13'd4;
			ar_y <= 13'd3;
		end else begin
			core_x <= next_x;
			core_y <= next_y;
			if (cfg.ar_mode == 2'd0) begin
				ar_x <= next_x;
				ar_y <= next_y;
			end else begin
				// Scaler preset index, y of zero marks it
				ar_x <= {11'd0, cfg.ar_mode - 2'd1};
				ar_y <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cart_download.sv
// Routes the host download stream to the PIF ROM, the N64 ROM copy and Game Boy RAM writes
`timescale 1ns/1ps
`default_nettype none
`include "n64_frontend_macros.svh"

module cart_download (
	input wire logic clk_1x,
	input wire logic RESET,
	input wire n64_frontend_pkg::dl_stream_t dl,
	input wire logic ram_ready,
	output logic dl_wait,
	output logic pif_wren,
	output n64_frontend_pkg::pif_addr_t pif_addr,
	output n64_frontend_pkg::ram_word_t pif_data,
	output logic ram_wr,
	output n64_frontend_pkg::dl_addr_t ram_addr,
	output n64_frontend_pkg::ram_word_t ram_data,
	output logic romcopy_start,
	output n64_frontend_pkg::dl_addr_t romcopy_size,
	output logic cart_loaded
);
	import n64_frontend_pkg::*;

	logic pif_active;
	logic n64_active;
	logic gb_active;
	logic download_d;
	logic n64_done;
	logic pif_beat;
	logic gb_beat;
	gb_pack_state_t gb_state;

	// ============================================================
	// Index decode, one cycle behind the stream
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_active <= 1'b0;
			n64_active <= 1'b0;
			gb_active <= 1'b0;
			download_d <= 1'b0;
		end else begin
			pif_active <= dl.download && (dl.index[5:0] == `N64FE_IDX_PIF);
			n64_active <= dl.download && (dl.index[5:0] == `N64FE_IDX_N64);
			gb_active <= dl.download && (dl.index[5:0] == `N64FE_IDX_GB);
			download_d <= dl.download;
		end
	end

	assign pif_beat = pif_active && dl.wr;
	assign gb_beat = gb_active && dl.wr && (gb_state != GB_WAIT);
	// Falling edge of an N64 cartridge transfer
	assign n64_done = !dl.download && download_d && (dl.index[5:0] == `N64FE_IDX_N64);

	// ============================================================
	// PIF ROM packer
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_wren <= 1'b0;
		end else begin
			pif_wren <= pif_beat && dl.addr[1];
		end
	end

	// Boot ROM expects each byte pair swapped
	always_ff @(posedge clk_1x) begin
		if (pif_beat) begin
			if (!dl.addr[1]) begin
				pif_data[31:16] <= {dl.dout[7:0], dl.dout[15:8]};
				pif_addr <= {dl.index[6], dl.addr[10:2]};
			end else begin
				pif_data[15:0] <= {dl.dout[7:0], dl.dout[15:8]};
			end
		end
	end

	// ============================================================
	// Game Boy packer
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			gb_state <= GB_LOW;
			ram_wr <= 1'b0;
			dl_wait <= 1'b0;
		end else begin
			ram_wr <= 1'b0;
			if (!gb_active) begin
				gb_state <= GB_LOW;
				dl_wait <= 1'b0;
			end else begin
				case (gb_state)
					GB_LOW, GB_HIGH: begin
						if (gb_beat && dl.addr[1]) begin
							ram_wr <= 1'b1;
							dl_wait <= 1'b1;
							gb_state <= GB_WAIT;
						end else if (gb_beat) begin
							gb_state <= GB_HIGH;
						end
					end
					// Sender is held until the RAM takes the word
					GB_WAIT: begin
						if (ram_ready) begin
							dl_wait <= 1'b0;
							gb_state <= GB_LOW;
						end
					end
					default: gb_state <= GB_LOW;
				endcase
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (gb_beat) begin
			if (!dl.addr[1]) begin
				ram_data[15:0] <= dl.dout;
				ram_addr <= dl.addr + `N64FE_GB_BASE;
			end else begin
				ram_data[31:16] <= dl.dout;
			end
		end
	end

	// ============================================================
	// N64 cartridge ROM copy start
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			romcopy_start <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			romcopy_start <= n64_done;
			if (n64_active) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (n64_done) begin
			romcopy_size <= dl.addr;
		end
	end

	// Write strobes only show up during a transfer of the right kind
	a_ram_wr_gb: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr |-> gb_active);
	a_pif_wren_pif: assert property (@(posedge clk_1x) disable iff (!RESET)
		pif_wren |-> pif_active);
	// Sender is only held inside a Game Boy transfer
	a_wait_gb: assert property (@(posedge clk_1x) disable iff (!RESET)
		dl_wait |-> gb_active);

endmodule

`default_nettype wire

// File: src/llapi_pad_mapper.sv
// Maps one decoded LLAPI controller onto the console pad word with centred sticks
`timescale 1ns/1ps
`default_nettype none
`include "n64_frontend_macros.svh"

module llapi_pad_mapper (
	input wire n64_frontend_pkg::llapi_port_t port,
	output n64_frontend_pkg::player_pad_t pad,
	output logic present
);
	import n64_frontend_pkg::*;

	// ============================================================
	// Button remap, LLAPI ids are HID ids minus one
	// ============================================================
	always_comb begin
		pad.buttons = {
			port.buttons[2],
			port.buttons[3],
			port.buttons[9],
			port.buttons[8],
			port.buttons[4],
			port.buttons[7],
			port.buttons[6],
			port.buttons[5],
			port.buttons[0],
			port.buttons[1],
			// Dpad up, down, left, right
			port.buttons[27],
			port.buttons[26],
			port.buttons[25],
			port.buttons[24]
		};
		// Unsigned raw byte to signed axis
		pad.stick_x = stick_t'(port.stick_x - `N64FE_STICK_CENTER);
		pad.stick_y = stick_t'(port.stick_y - `N64FE_STICK_CENTER);
	end

	// Type 0 also covers an Atari pad, treated as absent
	assign present = port.en
		&& (port.ctrl_type != `N64FE_TYPE_NONE)
		&& (port.ctrl_type != `N64FE_TYPE_SEARCH);

endmodule

`default_nettype wire

// File: src/n64_frontend_macros.svh
// Shared constants for the N64 front end, included by RTL files that decode downloads or pads
`ifndef N64_FRONTEND_MACROS_SVH
`define N64_FRONTEND_MACROS_SVH

// ============================================================
// Download transfer indices (low six bits of the index)
// ============================================================
`define N64FE_IDX_PIF 6'd0
`define N64FE_IDX_N64 6'd1
`define N64FE_IDX_GB 6'd2

// Byte offset of the Game Boy cartridge image in RAM
`define N64FE_GB_BASE 27'd8388608

// ============================================================
// LLAPI controller constants
// ============================================================
// Raw stick bytes are unsigned around this value
`define N64FE_STICK_CENTER 8'd128

// Both codes mean no usable controller on the port
`define N64FE_TYPE_NONE 8'd0
`define N64FE_TYPE_SEARCH 8'd255

`endif

// File: src/n64_frontend_pkg.sv
// Types shared by the N64 front end modules, imported where a module body needs them
`default_nettype none

package n64_frontend_pkg;

	// ============================================================
	// Plain vector types
	// ============================================================
	typedef logic [26:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;
	typedef logic [31:0] ram_word_t;
	typedef logic [9:0] pif_addr_t;
	typedef logic [7:0] dl_index_t;
	typedef logic signed [7:0] stick_t;
	typedef logic [31:0] llapi_buttons_t;
	typedef logic [12:0] ar_coord_t;

	// Bit 0 is dpad right, bit 13 is C left
	typedef logic [13:0] pad_buttons_t;

	// ============================================================
	// Bundles
	// ============================================================
	// Host download stream, wr pulses once per 16-bit beat
	typedef struct packed {
		logic download;
		dl_index_t index;
		dl_addr_t addr;
		dl_data_t dout;
		logic wr;
	} dl_stream_t;

	// Decoded LLAPI controller, sticks still raw
	typedef struct packed {
		llapi_buttons_t buttons;
		logic [7:0] stick_x;
		logic [7:0] stick_y;
		logic [7:0] ctrl_type;
		logic en;
	} llapi_port_t;

	typedef struct packed {
		pad_buttons_t buttons;
		stick_t stick_x;
		stick_t stick_y;
	} player_pad_t;

	typedef struct packed {
		logic pal;
		logic [1:0] crop;
		logic blanks_off;
		logic direct_fb;
		logic [1:0] ar_mode;
	} video_cfg_t;

	// Game Boy beat packer
	typedef enum logic [1:0] {
		GB_LOW,
		GB_HIGH,
		GB_WAIT
	} gb_pack_state_t;

endpackage

`default_nettype wire

// File: src/n64_frontend_top.sv
// Top level of the N64 front end, joining download routing, pad mapping and aspect selection
`timescale 1ns/1ps
`default_nettype none

module n64_frontend_top (
	input wire logic clk_1x,
	input wire logic RESET,
	input wire n64_frontend_pkg::dl_stream_t dl,
	input wire logic ram_ready,
	output logic dl_wait,
	output logic pif_wren,
	output n64_frontend_pkg::pif_addr_t pif_addr,
	output n64_frontend_pkg::ram_word_t pif_data,
	output logic ram_wr,
	output n64_frontend_pkg::dl_addr_t ram_addr,
	output n64_frontend_pkg::ram_word_t ram_data,
	output logic romcopy_start,
	output n64_frontend_pkg::dl_addr_t romcopy_size,
	output logic cart_loaded,
	input wire n64_frontend_pkg::llapi_port_t llapi_a,
	input wire n64_frontend_pkg::llapi_port_t llapi_b,
	input wire n64_frontend_pkg::player_pad_t usb0,
	input wire n64_frontend_pkg::player_pad_t usb1,
	input wire n64_frontend_pkg::player_pad_t usb2,
	output n64_frontend_pkg::player_pad_t player0,
	output n64_frontend_pkg::player_pad_t player1,
	output n64_frontend_pkg::player_pad_t player2,
	output n64_frontend_pkg::player_pad_t player3,
	output logic osd_request,
	input wire n64_frontend_pkg::video_cfg_t video_cfg,
	output n64_frontend_pkg::ar_coord_t ar_x,
	output n64_frontend_pkg::ar_coord_t ar_y
);
	import n64_frontend_pkg::*;

	player_pad_t pad_a;
	player_pad_t pad_b;
	logic present_a;
	logic present_b;

	// ============================================================
	// Download path
	// ============================================================
	cart_download u_cart_download (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.dl(dl),
		.ram_ready(ram_ready),
		.dl_wait(dl_wait),
		.pif_wren(pif_wren),
		.pif_addr(pif_addr),
		.pif_data(pif_data),
		.ram_wr(ram_wr),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.romcopy_start(romcopy_start),
		.romcopy_size(romcopy_size),
		.cart_loaded(cart_loaded)
	);

	// ============================================================
	// Controllers
	// ============================================================
	llapi_pad_mapper u_map_a (
		.port(llapi_a),
		.pad(pad_a),
		.present(present_a)
	);

	llapi_pad_mapper u_map_b (
		.port(llapi_b),
		.pad(pad_b),
		.present(present_b)
	);

	player_allocator u_player_allocator (
		.ll_a(pad_a),
		.ll_b(pad_b),
		.present_a(present_a),
		.present_b(present_b),
		.raw_a(llapi_a.buttons),
		.raw_b(llapi_b.buttons),
		.usb0(usb0),
		.usb1(usb1),
		.usb2(usb2),
		.player0(player0),
		.player1(player1),
		.player2(player2),
		.player3(player3),
		.osd_request(osd_request)
	);

	// Video aspect
	aspect_ratio_select u_aspect_ratio_select (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.cfg(video_cfg),
		.ar_x(ar_x),
		.ar_y(ar_y)
	);

endmodule

`default_nettype wire

// File: src/player_allocator.sv
// Allocates LLAPI and USB pads to the four player slots and raises the OSD button request
`timescale 1ns/1ps
`default_nettype none

module player_allocator (
	input wire n64_frontend_pkg::player_pad_t ll_a,
	input wire n64_frontend_pkg::player_pad_t ll_b,
	input wire logic present_a,
	input wire logic present_b,
	input wire n64_frontend_pkg::llapi_buttons_t raw_a,
	input wire n64_frontend_pkg::llapi_buttons_t raw_b,
	input wire n64_frontend_pkg::player_pad_t usb0,
	input wire n64_frontend_pkg::player_pad_t usb1,
	input wire n64_frontend_pkg::player_pad_t usb2,
	output n64_frontend_pkg::player_pad_t player0,
	output n64_frontend_pkg::player_pad_t player1,
	output n64_frontend_pkg::player_pad_t player2,
	output n64_frontend_pkg::player_pad_t player3,
	output logic osd_request
);

	logic only_b;

	// Down, start and first face button held together
	function automatic logic osd_combo(input n64_frontend_pkg::llapi_buttons_t b);
		return b[26] && b[5] && b[0];
	endfunction

	// ============================================================
	// Slot allocation
	// ============================================================
	// Lone controller on port B takes player 1
	assign only_b = !present_a && present_b;

	always_comb begin
		if (only_b) begin
			player0 = ll_b;
			player1 = usb0;
			player2 = usb1;
			player3 = usb2;
		end else begin
			player0 = ll_a;
			player1 = ll_b;
			player2 = usb0;
			player3 = usb1;
		end
	end

	assign osd_request = osd_combo(raw_a) || osd_combo(raw_b);

endmodule

`default_nettype wire

// File: testbench/frontend_cases.txt
# P index addr lo hi exp_pif_addr exp_pif_data | G addr lo hi exp_ram_addr exp_ram_data
# N last_addr | C en_a type_a btn_a en_b type_b btn_b usb0 usb1 usb2 | O raw_a raw_b exp
# A pal crop blanks_off direct_fb ar_mode exp_ar_x exp_ar_y (all fields hexadecimal)
P 00 0000010 1234 5678 004 34127856
P 40 00007fc abcd ef01 3ff cdab01ef
P 40 0000200 0011 2233 280 11003322
G 0000100 1111 2222 0800100 22221111
G 0001ffc beef dead 0801ffc deadbeef
G 07ffff0 a5a5 5a5a 0fffff0 5a5aa5a5
N 0000400
N 3fffffc
C 1 01 0f0003ff 1 03 00000021 01234567 2abcdef0 00000f0f
C 0 01 00000001 1 05 08000010 11111111 22222222 33333333
C 1 00 ffffffff 1 02 0000ffff 3fffffff 00000000 15555555
C 1 ff 00000000 1 ff 00000000 00000001 00000002 00000003
C 1 02 01000002 0 02 00000000 0aaaaaaa 05555555 3c3c3c3c
C 1 ff 02000004 1 07 0c000300 12345678 23456789 3456789a
O 04000021 00000000 1
O 00000000 04000021 1
O 04000020 04000001 0
O ffffffff 00000000 1
O 00000021 00000000 0
O 00000000 00000000 0
A 0 0 0 0 0 200 17d
A 0 1 0 0 0 500 379
A 0 2 0 0 0 a00 6b2
A 0 3 0 0 0 a00 6b2
A 1 0 0 0 0 200 183
A 1 1 0 0 0 400 2db
A 1 2 0 0 0 800 58b
A 1 2 1 0 0 4 3
A 1 3 0 0 0 4 3
A 0 1 0 1 2 1 0
A 0 1 0 0 3 2 0
A 0 3 0 0 0 500 379

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the N64 front end testbench, instantiated by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_1x,
	output logic RESET
);

	// 40 ns period
	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	// Reset held low over ten rising edges
	initial begin
		RESET = 1'b0;
		repeat (10) @(posedge clk_1x);
		#1 RESET = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_n64_frontend.sv
// Testbench for the N64 front end, replays the case file against the DUT and reports the result
`timescale 1ns/1ps
`default_nettype none

module tb_n64_frontend;
	import n64_frontend_pkg::*;

	localparam int TIMEOUT = 40;

	logic clk_1x;
	logic RESET;
	dl_stream_t dl;
	logic ram_ready;
	logic dl_wait;
	logic pif_wren;
	pif_addr_t pif_addr;
	ram_word_t pif_data;
	logic ram_wr;
	dl_addr_t ram_addr;
	ram_word_t ram_data;
	logic romcopy_start;
	dl_addr_t romcopy_size;
	logic cart_loaded;
	llapi_port_t llapi_a;
	llapi_port_t llapi_b;
	player_pad_t usb0;
	player_pad_t usb1;
	player_pad_t usb2;
	player_pad_t player0;
	player_pad_t player1;
	player_pad_t player2;
	player_pad_t player3;
	logic osd_request;
	video_cfg_t video_cfg;
	ar_coord_t ar_x;
	ar_coord_t ar_y;

	integer seed;
	integer errors;
	integer failures;
	integer cases;
	integer fd;
	integer c;
	integer n;
	logic [7:0] ch;
	logic [31:0] f0;
	logic [31:0] f1;
	logic [31:0] f2;
	logic [31:0] f3;
	logic [31:0] f4;
	logic [31:0] f5;
	logic [31:0] f6;
	logic [31:0] f7;
	logic [31:0] f8;

	tb_clock_gen u_clock_gen (
		.clk_1x(clk_1x),
		.RESET(RESET)
	);

	n64_frontend_top u_dut (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.dl(dl),
		.ram_ready(ram_ready),
		.dl_wait(dl_wait),
		.pif_wren(pif_wren),
		.pif_addr(pif_addr),
		.pif_data(pif_data),
		.ram_wr(ram_wr),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.romcopy_start(romcopy_start),
		.romcopy_size(romcopy_size),
		.cart_loaded(cart_loaded),
		.llapi_a(llapi_a),
		.llapi_b(llapi_b),
		.usb0(usb0),
		.usb1(usb1),
		.usb2(usb2),
		.player0(player0),
		.player1(player1),
		.player2(player2),
		.player3(player3),
		.osd_request(osd_request),
		.video_cfg(video_cfg),
		.ar_x(ar_x),
		.ar_y(ar_y)
	);

	// ============================================================
	// Helpers
	// ============================================================
	// Inputs change 2 ns after the rising edge
	task automatic tick;
		@(posedge clk_1x);
		#2;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errors = errors + 1;
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic report_timeout(input string what);
		failures = failures + 1;
		$display("Timed out at %0t ns while waiting for %s", $time, what);
	endtask

	task automatic end_transfer;
		dl.wr = 1'b0;
		dl.download = 1'b0;
		tick;
		tick;
	endtask

	// Pad word bit order: dpad R L D U, A, B, start, L, R, Z, C up R D L
	function automatic player_pad_t expect_pad(input logic [31:0] b, input logic [7:0] sx,
			input logic [7:0] sy);
		player_pad_t p;
		p.buttons[0] = b[24];
		p.buttons[1] = b[25];
		p.buttons[2] = b[26];
		p.buttons[3] = b[27];
		p.buttons[4] = b[1];
		p.buttons[5] = b[0];
		p.buttons[6] = b[5];
		p.buttons[7] = b[6];
		p.buttons[8] = b[7];
		p.buttons[9] = b[4];
		p.buttons[10] = b[8];
		p.buttons[11] = b[9];
		p.buttons[12] = b[3];
		p.buttons[13] = b[2];
		p.stick_x = sx - 8'd128;
		p.stick_y = sy - 8'd128;
		return p;
	endfunction

	// ============================================================
	// Case runners
	// ============================================================
	task automatic run_pif(input logic [7:0] idx, input logic [26:0] addr,
			input logic [15:0] lo, input logic [15:0] hi,
			input logic [9:0] exp_addr, input logic [31:0] exp_data);
		integer k;
		dl.download = 1'b1;
		dl.index = idx;
		dl.addr = addr;
		tick;
		dl.wr = 1'b1;
		dl.dout = lo;
		tick;
		dl.addr = addr | 27'd2;
		dl.dout = hi;
		tick;
		dl.wr = 1'b0;
		k = 0;
		while (!pif_wren && k < TIMEOUT) begin
			tick;
			k = k + 1;
		end
		if (!pif_wren) begin
			report_timeout("the PIF ROM write strobe");
			return;
		end
		if (pif_addr !== exp_addr)
			report_mismatch("pif_addr", {22'd0, pif_addr}, {22'd0, exp_addr});
		if (pif_data !== exp_data)
			report_mismatch("pif_data", pif_data, exp_data);
		tick;
		if (pif_wren !== 1'b0)
			report_mismatch("pif_wren after its pulse", {31'd0, pif_wren}, 32'd0);
		end_transfer;
	endtask

	task automatic run_gb(input logic [26:0] addr, input logic [15:0] lo,
			input logic [15:0] hi, input logic [26:0] exp_addr, input logic [31:0] exp_data);
		integer k;
		integer delay;
		dl.download = 1'b1;
		dl.index = 8'd2;
		dl.addr = addr;
		tick;
		dl.wr = 1'b1;
		dl.dout = lo;
		tick;
		dl.addr = addr | 27'd2;
		dl.dout = hi;
		tick;
		dl.wr = 1'b0;
		k = 0;
		while (!ram_wr && k < TIMEOUT) begin
			tick;
			k = k + 1;
		end
		if (!ram_wr) begin
			report_timeout("the Game Boy RAM write strobe");
			return;
		end
		if (ram_addr !== exp_addr)
			report_mismatch("ram_addr", {5'd0, ram_addr}, {5'd0, exp_addr});
		if (ram_data !== exp_data)
			report_mismatch("ram_data", ram_data, exp_data);
		// Sender stays held until the RAM answers
		if (dl_wait !== 1'b1)
			report_mismatch("wait with the RAM write", {31'd0, dl_wait}, 32'd1);
		delay = 1 + ($random(seed) & 7);
		repeat (delay) begin
			tick;
			if (ram_wr !== 1'b0)
				report_mismatch("ram_wr after its pulse", {31'd0, ram_wr}, 32'd0);
			if (dl_wait !== 1'b1)
				report_mismatch("wait before ram_ready", {31'd0, dl_wait}, 32'd1);
		end
		ram_ready = 1'b1;
		tick;
		ram_ready = 1'b0;
		if (dl_wait !== 1'b0)
			report_mismatch("wait after ram_ready", {31'd0, dl_wait}, 32'd0);
		end_transfer;
	endtask

	task automatic run_n64(input logic [26:0] last);
		integer k;
		logic [31:0] rnd;
		dl.download = 1'b1;
		dl.index = 8'd1;
		dl.addr = last - 27'd4;
		tick;
		rnd = $random(seed);
		dl.wr = 1'b1;
		dl.dout = rnd[15:0];
		tick;
		dl.addr = last - 27'd2;
		tick;
		dl.addr = last;
		tick;
		dl.wr = 1'b0;
		tick;
		// Address stays on the last beat while download drops
		dl.download = 1'b0;
		tick;
		k = 0;
		while (!romcopy_start && k < TIMEOUT) begin
			tick;
			k = k + 1;
		end
		if (!romcopy_start) begin
			report_timeout("the ROM copy start pulse");
			return;
		end
		if (romcopy_size !== last)
			report_mismatch("romcopy_size", {5'd0, romcopy_size}, {5'd0, last});
		if (cart_loaded !== 1'b1)
			report_mismatch("cart_loaded", {31'd0, cart_loaded}, 32'd1);
		tick;
		if (romcopy_start !== 1'b0)
			report_mismatch("romcopy_start after its pulse", {31'd0, romcopy_start}, 32'd0);
	endtask

	task automatic run_pad(input logic en_a, input logic [7:0] type_a, input logic [31:0] btn_a,
			input logic en_b, input logic [7:0] type_b, input logic [31:0] btn_b,
			input logic [29:0] u0, input logic [29:0] u1, input logic [29:0] u2);
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		logic pres_a;
		logic pres_b;
		player_pad_t pad_a;
		player_pad_t pad_b;
		player_pad_t exp0;
		player_pad_t exp1;
		player_pad_t exp2;
		player_pad_t exp3;
		rnd_a = $random(seed);
		rnd_b = $random(seed);
		llapi_a = {btn_a, rnd_a[7:0], rnd_a[15:8], type_a, en_a};
		llapi_b = {btn_b, rnd_b[7:0], rnd_b[15:8], type_b, en_b};
		usb0 = u0;
		usb1 = u1;
		usb2 = u2;
		pad_a = expect_pad(btn_a, rnd_a[7:0], rnd_a[15:8]);
		pad_b = expect_pad(btn_b, rnd_b[7:0], rnd_b[15:8]);
		pres_a = en_a && (type_a != 8'h00) && (type_a != 8'hff);
		pres_b = en_b && (type_b != 8'h00) && (type_b != 8'hff);
		// Port B moves to player 1 when it is the only LLAPI pad
		if (!pres_a && pres_b) begin
			exp0 = pad_b;
			exp1 = u0;
			exp2 = u1;
			exp3 = u2;
		end else begin
			exp0 = pad_a;
			exp1 = pad_b;
			exp2 = u0;
			exp3 = u1;
		end
		tick;
		if (player0 !== exp0)
			report_mismatch("player0", {2'b00, player0}, {2'b00, exp0});
		if (player1 !== exp1)
			report_mismatch("player1", {2'b00, player1}, {2'b00, exp1});
		if (player2 !== exp2)
			report_mismatch("player2", {2'b00, player2}, {2'b00, exp2});
		if (player3 !== exp3)
			report_mismatch("player3", {2'b00, player3}, {2'b00, exp3});
	endtask

	task automatic run_osd(input logic [31:0] raw_a, input logic [31:0] raw_b,
			input logic exp);
		llapi_a.buttons = raw_a;
		llapi_b.buttons = raw_b;
		tick;
		if (osd_request !== exp)
			report_mismatch("osd_request", {31'd0, osd_request}, {31'd0, exp});
	endtask

	task automatic run_aspect(input video_cfg_t cfg, input logic [12:0] exp_x,
			input logic [12:0] exp_y);
		video_cfg = cfg;
		tick;
		tick;
		if (ar_x !== exp_x)
			report_mismatch("ar_x", {19'd0, ar_x}, {19'd0, exp_x});
		if (ar_y !== exp_y)
			report_mismatch("ar_y", {19'd0, ar_y}, {19'd0, exp_y});
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		seed = 32'h78ee_786e;
		errors = 0;
		failures = 0;
		cases = 0;
		dl = '0;
		ram_ready = 1'b0;
		llapi_a = '0;
		llapi_b = '0;
		usb0 = '0;
		usb1 = '0;
		usb2 = '0;
		video_cfg = '0;

		n = 0;
		while (RESET !== 1'b1 && n < 30) begin
			tick;
			n = n + 1;
		end
		if (RESET !== 1'b1)
			report_timeout("the end of reset");

		// Reset values, before any edge with reset released
		if ({pif_wren, ram_wr, dl_wait, romcopy_start, cart_loaded} !== 5'd0)
			report_mismatch("strobes after reset",
				{27'd0, pif_wren, ram_wr, dl_wait, romcopy_start, cart_loaded}, 32'd0);
		if (ar_x !== 13'd4 || ar_y !== 13'd3)
			report_mismatch("aspect after reset", {3'd0, ar_x, 3'd0, ar_y},
				{16'd4, 16'd3});

		fd = $fopen("testbench/frontend_cases.txt", "r");
		if (fd == 0) begin
			failures = failures + 1;
			$display("Could not open the case file testbench/frontend_cases.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1 && failures == 0) begin
				ch = c[7:0];
				if (ch == "#") begin
					while (c != -1 && c[7:0] != 8'h0a)
						c = $fgetc(fd);
				end else if (ch == "P") begin
					n = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
					if (n == 6) begin
						cases = cases + 1;
						run_pif(f0[7:0], f1[26:0], f2[15:0], f3[15:0], f4[9:0], f5);
					end else begin
						failures = failures + 1;
						$display("A PIF case line in the case file is malformed");
					end
				end else if (ch == "G") begin
					n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
					if (n == 5) begin
						cases = cases + 1;
						run_gb(f0[26:0], f1[15:0], f2[15:0], f3[26:0], f4);
					end else begin
						failures = failures + 1;
						$display("A Game Boy case line in the case file is malformed");
					end
				end else if (ch == "N") begin
					n = $fscanf(fd, "%h", f0);
					if (n == 1) begin
						cases = cases + 1;
						run_n64(f0[26:0]);
					end else begin
						failures = failures + 1;
						$display("An N64 case line in the case file is malformed");
					end
				end else if (ch == "C") begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
						f0, f1, f2, f3, f4, f5, f6, f7, f8);
					if (n == 9) begin
						cases = cases + 1;
						run_pad(f0[0], f1[7:0], f2, f3[0], f4[7:0], f5,
							f6[29:0], f7[29:0], f8[29:0]);
					end else begin
						failures = failures + 1;
						$display("A pad case line in the case file is malformed");
					end
				end else if (ch == "O") begin
					n = $fscanf(fd, "%h %h %h", f0, f1, f2);
					if (n == 3) begin
						cases = cases + 1;
						run_osd(f0, f1, f2[0]);
					end else begin
						failures = failures + 1;
						$display("An OSD case line in the case file is malformed");
					end
				end else if (ch == "A") begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
					if (n == 7) begin
						cases = cases + 1;
						run_aspect({f0[0], f1[1:0], f2[0], f3[0], f4[1:0]},
							f5[12:0], f6[12:0]);
					end else begin
						failures = failures + 1;
						$display("An aspect case line in the case file is malformed");
					end
				end else if (ch != 8'h20 && ch != 8'h0a && ch != 8'h0d && ch != 8'h09) begin
					failures = failures + 1;
					$display("The case file holds an unknown case letter %c", ch);
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end

		$display("Cases run: %0d, value errors: %0d, other failures: %0d",
			cases, errors, failures);
		if (errors == 0 && failures == 0 && cases > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/n64_frontend_pkg.sv
src/cart_download.sv
src/llapi_pad_mapper.sv
src/player_allocator.sv
src/aspect_ratio_select.sv
src/n64_frontend_top.sv
testbench/tb_clock_gen.sv
testbench/tb_n64_frontend.sv
